//--- design/nic_rx_defs.svh
// Global sizing macros for the receive path
// Buffer address width, MAC word width, drop counter width

`ifndef NIC_RX_DEFS_SVH
`define NIC_RX_DEFS_SVH

// --------------------
// Packet buffer
// --------------------

// 64 words, small enough to overflow in simulation
`define RX_BUF_AW 6

// --------------------
// MAC side
// --------------------

// 10G MAC client data path
`define MAC_DW 64

// --------------------
// Statistics
// --------------------

`define DROP_CNT_W 16           // Dropped frame counter, wraps

`endif

//--- design/mac_rx_pkg.sv
// MAC receive side types
// Data word, byte-valid mask, frame length and byte lane helpers

`include "nic_rx_defs.svh"

package mac_rx_pkg;

    // --------------------
    // Word level
    // --------------------
    typedef logic [`MAC_DW-1:0]   mac_word_t;   // One client data word
    typedef logic [`MAC_DW/8-1:0] mac_valid_t;  // Lane mask, contiguous from lane 0

    // Length bits that select a lane inside a word
    localparam int BYTE_SEL_W = $clog2(`MAC_DW/8);

    localparam mac_valid_t KEEP_ALL = '1;       // Full word

    // --------------------
    // Frame level
    // --------------------
    typedef logic [15:0] frame_len_t;           // Bytes, header carries this

endpackage

//--- design/rx_buf_pkg.sv
// Packet buffer types
// Word address, wrapped pointer, drop count, stored header layout

`include "nic_rx_defs.svh"

package rx_buf_pkg;

    import mac_rx_pkg::*;

    // --------------------
    // Addressing
    // --------------------
    typedef logic [`RX_BUF_AW-1:0] buf_addr_t;  // RAM word address
    typedef logic [`RX_BUF_AW:0]   buf_ptr_t;   // Extra wrap bit, full differs from empty

    // Total slots, in pointer width for free space maths
    localparam buf_ptr_t BUF_DEPTH = buf_ptr_t'(1 << `RX_BUF_AW);

    typedef logic [`DROP_CNT_W-1:0] drop_cnt_t;

    // --------------------
    // Header slot in front of each frame
    // --------------------
    typedef struct packed {
        logic [`MAC_DW-$bits(frame_len_t)-1:0] rsvd;  // Always zero
        frame_len_t                             len;   // Byte length of the frame
    } hdr_word_t;

endpackage

//--- design/rx_frame_capture.sv
// MAC receive writer
// Stores words behind a header slot, commits good frames,
// rewinds bad or oversized ones and counts the drops

`timescale 1ns/10ps

module rx_frame_capture (
    input  logic                   clk156_25,
    input  logic                   rst,
    // MAC client rx
    input  mac_rx_pkg::mac_word_t  mac_rx_data,
    input  mac_rx_pkg::mac_valid_t mac_rx_data_valid,
    input  logic                   mac_rx_good_frame,
    input  logic                   mac_rx_bad_frame,
    // Space freed by the reader
    input  rx_buf_pkg::buf_ptr_t   commit_rd_ptr,
    // Buffer write port
    output logic                   wr_en,
    output rx_buf_pkg::buf_addr_t  wr_addr,
    output mac_rx_pkg::mac_word_t  wr_data,
    // To reader and host
    output rx_buf_pkg::buf_ptr_t   commit_wr_ptr,
    output rx_buf_pkg::drop_cnt_t  dropped_pkts
);

    import mac_rx_pkg::*;
    import rx_buf_pkg::*;

    buf_ptr_t   start_ptr;              // Header slot of frame in flight
    buf_ptr_t   wr_ptr;                 // Next payload slot
    frame_len_t byte_len;               // Running byte count
    logic       ovf;                    // Frame ran out of room

    logic       word_vld;
    logic       frame_end;
    buf_ptr_t   free_slots;
    buf_ptr_t   frame_slots;
    logic       word_fits;
    logic       commit_ok;
    hdr_word_t  hdr;

    // --------------------
    // Space accounting
    // --------------------
    assign word_vld    = |mac_rx_data_valid;
    assign frame_end   = mac_rx_good_frame | mac_rx_bad_frame;

    assign free_slots  = BUF_DEPTH - (start_ptr - commit_rd_ptr);   // Committed data only
    assign frame_slots = wr_ptr - start_ptr;                        // Header plus words so far
    assign word_fits   = frame_slots < free_slots;                  // Room for one more

    // Good frame with no overflow and header slot free
    assign commit_ok   = mac_rx_good_frame && !ovf && (frame_slots <= free_slots);

    // The frame start is the committed write position
    assign commit_wr_ptr = start_ptr;

    always_comb begin
        hdr     = '0;
        hdr.len = byte_len;             // Upper bits stay zero
    end

    // --------------------
    // Buffer write port
    // --------------------
    always_comb begin
        wr_en   = 1'b0;
        wr_addr = buf_addr_t'(wr_ptr);  // Drop wrap bit
        wr_data = mac_rx_data;
        if (commit_ok) begin
            wr_en   = 1'b1;                         // Header on the good pulse
            wr_addr = buf_addr_t'(start_ptr);
            wr_data = mac_word_t'(hdr);
        end else if (word_vld && !ovf && word_fits) begin
            wr_en   = 1'b1;                         // Payload word as it arrives
        end
    end

    // --------------------
    // Pointers, length, drop count
    // --------------------
    always_ff @(posedge clk156_25) begin
        if (rst) begin
            start_ptr    <= '0;
            wr_ptr       <= buf_ptr_t'(1);          // First payload slot after header
            byte_len     <= '0;
            ovf          <= 1'b0;
            dropped_pkts <= '0;
        end else begin
            if (frame_end) begin
                byte_len <= '0;
                ovf      <= 1'b0;
                if (commit_ok) begin
                    start_ptr <= wr_ptr;                    // Publish frame
                    wr_ptr    <= wr_ptr + 1'b1;             // Skip next header slot
                end else begin
                    wr_ptr       <= start_ptr + 1'b1;       // Rewind to last commit
                    dropped_pkts <= dropped_pkts + 1'b1;
                end
            end else if (word_vld) begin
                byte_len <= byte_len + frame_len_t'($countones(mac_rx_data_valid));
                if (ovf || !word_fits) begin
                    ovf <= 1'b1;                            // Sticky until frame end
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    // --------------------
    // MAC protocol checks
    // --------------------
    a_end_exclusive: assert property (@(posedge clk156_25) disable iff (rst)
        !(mac_rx_good_frame && mac_rx_bad_frame));

    // End pulse arrives on its own cycle, after the last word
    a_end_no_word: assert property (@(posedge clk156_25) disable iff (rst)
        frame_end |-> (mac_rx_data_valid == '0));

endmodule

//--- design/rx_packet_buffer.sv
// Receive packet RAM
// One write port, one read port with registered output

`timescale 1ns/10ps

`include "nic_rx_defs.svh"

module rx_packet_buffer #(
    parameter int AW = `RX_BUF_AW           // Word address bits
) (
    input  logic                  clk156_25,
    input  logic                  wr_en,
    input  logic [AW-1:0]         wr_addr,
    input  mac_rx_pkg::mac_word_t wr_data,
    input  logic [AW-1:0]         rd_addr,
    output mac_rx_pkg::mac_word_t rd_data
);

    import mac_rx_pkg::*;

    mac_word_t mem [0:(1<<AW)-1];           // Headers and payload

    // Write side, capture stage
    always_ff @(posedge clk156_25) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read side, one cycle after the address
    always_ff @(posedge clk156_25) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- design/rx_host_reader.sv
// Host side reader
// Fetches committed frames from the packet buffer and streams them
// out with sof, eof, keep and destination-ready back-pressure

`timescale 1ns/10ps

module rx_host_reader (
    input  logic                   clk156_25,
    input  logic                   rst,
    input  rx_buf_pkg::buf_ptr_t   commit_wr_ptr,
    // Buffer read port
    output rx_buf_pkg::buf_addr_t  rd_addr,
    input  mac_rx_pkg::mac_word_t  rd_data,
    output rx_buf_pkg::buf_ptr_t   commit_rd_ptr,
    // Host local-link
    output mac_rx_pkg::mac_word_t  pkt_data,
    output mac_rx_pkg::mac_valid_t pkt_keep,
    output logic                   pkt_sof,
    output logic                   pkt_eof,
    output mac_rx_pkg::frame_len_t pkt_len,
    output logic                   pkt_src_rdy,
    input  logic                   pkt_dst_rdy
);

    import mac_rx_pkg::*;
    import rx_buf_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,                         // Wait for a committed frame
        S_HDR,                          // Header on rd_data, first word requested
        S_FETCH,                        // Next word requested
        S_PRESENT                       // Word on the port
    } rd_state_t;

    rd_state_t  state;
    buf_ptr_t   rd_ptr;                 // Slot of the current word
    frame_len_t len_q;
    frame_len_t words_left;             // Including the presented one
    mac_valid_t last_keep;
    logic       sof_pend;
    hdr_word_t  hdr;
    frame_len_t hdr_words;
    logic       accept;

    // --------------------
    // Header decode
    // --------------------
    assign hdr       = hdr_word_t'(rd_data);
    assign hdr_words = (hdr.len >> BYTE_SEL_W) + frame_len_t'(|hdr.len[BYTE_SEL_W-1:0]);

    // Read address held through present, so rd_data stays put
    assign rd_addr = (state == S_IDLE) ? buf_addr_t'(commit_rd_ptr) : buf_addr_t'(rd_ptr);

    // --------------------
    // Host port
    // --------------------
    assign pkt_src_rdy = (state == S_PRESENT);
    assign accept      = pkt_src_rdy && pkt_dst_rdy;
    assign pkt_data    = rd_data;
    assign pkt_sof     = pkt_src_rdy && sof_pend;
    assign pkt_eof     = pkt_src_rdy && (words_left == frame_len_t'(1));
    assign pkt_keep    = pkt_eof ? last_keep : KEEP_ALL;    // Partial lanes on eof only
    assign pkt_len     = len_q;

    // --------------------
    // Fetch FSM
    // --------------------
    always_ff @(posedge clk156_25) begin
        if (rst) begin
            state         <= S_IDLE;
            rd_ptr        <= '0;
            commit_rd_ptr <= '0;
            sof_pend      <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (commit_wr_ptr != commit_rd_ptr) begin
                        rd_ptr <= commit_rd_ptr + 1'b1;     // Payload follows header
                        state  <= S_HDR;
                    end
                end
                S_HDR: begin
                    sof_pend <= 1'b1;
                    if (hdr_words == '0) begin
                        commit_rd_ptr <= rd_ptr;            // Empty frame, release header
                        state         <= S_IDLE;
                    end else begin
                        state <= S_PRESENT;
                    end
                end
                S_FETCH: begin
                    state <= S_PRESENT;
                end
                S_PRESENT: begin
                    if (accept) begin
                        sof_pend <= 1'b0;
                        rd_ptr   <= rd_ptr + 1'b1;
                        if (pkt_eof) begin
                            commit_rd_ptr <= rd_ptr + 1'b1; // Hand space back
                            state         <= S_IDLE;
                        end else begin
                            state <= S_FETCH;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Frame bookkeeping, loaded from the header
    always_ff @(posedge clk156_25) begin
        if (state == S_HDR) begin
            len_q      <= hdr.len;
            words_left <= hdr_words;
            if (hdr.len[BYTE_SEL_W-1:0] == '0) begin
                last_keep <= KEEP_ALL;
            end else begin
                last_keep <= ~(KEEP_ALL << hdr.len[BYTE_SEL_W-1:0]);
            end
        end else if (accept) begin
            words_left <= words_left - 1'b1;
        end
    end

    // Offered word holds until taken, across the RAM read port
    a_hold_data: assert property (@(posedge clk156_25) disable iff (rst)
        (pkt_src_rdy && !pkt_dst_rdy) |=> (pkt_src_rdy && $stable(pkt_data)));

endmodule

//--- design/nic_rx_top.sv
// Receive path top level
// Frame capture, packet buffer and host reader on the MAC clock

`timescale 1ns/10ps

module nic_rx_top (
    input  logic                   clk156_25,
    input  logic                   rst,
    // MAC client rx
    input  mac_rx_pkg::mac_word_t  mac_rx_data,
    input  mac_rx_pkg::mac_valid_t mac_rx_data_valid,
    input  logic                   mac_rx_good_frame,
    input  logic                   mac_rx_bad_frame,
    // Host local-link
    output mac_rx_pkg::mac_word_t  pkt_data,
    output mac_rx_pkg::mac_valid_t pkt_keep,
    output logic                   pkt_sof,
    output logic                   pkt_eof,
    output mac_rx_pkg::frame_len_t pkt_len,
    output logic                   pkt_src_rdy,
    input  logic                   pkt_dst_rdy,
    // Statistics
    output rx_buf_pkg::drop_cnt_t  dropped_pkts
);

    import mac_rx_pkg::*;
    import rx_buf_pkg::*;

    // --------------------
    // Buffer ports
    // --------------------
    logic      wr_en;
    buf_addr_t wr_addr;
    mac_word_t wr_data;
    buf_addr_t rd_addr;
    mac_word_t rd_data;

    // Committed positions between the stages
    buf_ptr_t  commit_wr_ptr;
    buf_ptr_t  commit_rd_ptr;

    rx_frame_capture rx_frame_capture_mod (
        .clk156_25        (clk156_25),
        .rst              (rst),
        .mac_rx_data      (mac_rx_data),
        .mac_rx_data_valid(mac_rx_data_valid),
        .mac_rx_good_frame(mac_rx_good_frame),
        .mac_rx_bad_frame (mac_rx_bad_frame),
        .commit_rd_ptr    (commit_rd_ptr),      // Freed by reader
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .commit_wr_ptr    (commit_wr_ptr),
        .dropped_pkts     (dropped_pkts)
    );

    rx_packet_buffer #(.AW($bits(buf_addr_t))) rx_packet_buffer_mod (
        .clk156_25(clk156_25),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)                     // One cycle after rd_addr
    );

    rx_host_reader rx_host_reader_mod (
        .clk156_25    (clk156_25),
        .rst          (rst),
        .commit_wr_ptr(commit_wr_ptr),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .commit_rd_ptr(commit_rd_ptr),
        .pkt_data     (pkt_data),
        .pkt_keep     (pkt_keep),
        .pkt_sof      (pkt_sof),
        .pkt_eof      (pkt_eof),
        .pkt_len      (pkt_len),
        .pkt_src_rdy  (pkt_src_rdy),
        .pkt_dst_rdy  (pkt_dst_rdy)
    );

endmodule

//--- testbench/nic_rx_tb.sv
// Receive path testbench
// Vector driven MAC frames, random host back-pressure, host sink
// with a model queue of committed frames, compare tasks and timeouts

`timescale 1ns/10ps

`include "nic_rx_defs.svh"

module nic_rx_tb;

    import mac_rx_pkg::*;
    import rx_buf_pkg::*;

    localparam int DEPTH         = 1 << `RX_BUF_AW;    // Buffer slots
    localparam int LANES         = `MAC_DW / 8;
    localparam int ROOM_TIMEOUT  = 4000;               // Cycles
    localparam int DRAIN_TIMEOUT = 8000;
    localparam int MAX_LINES     = 200;

    logic       clk156_25;
    logic       rst;
    mac_word_t  mac_rx_data;
    mac_valid_t mac_rx_data_valid;
    logic       mac_rx_good_frame;
    logic       mac_rx_bad_frame;
    mac_word_t  pkt_data;
    mac_valid_t pkt_keep;
    logic       pkt_sof;
    logic       pkt_eof;
    frame_len_t pkt_len;
    logic       pkt_src_rdy;
    logic       pkt_dst_rdy;
    drop_cnt_t  dropped_pkts;

    logic [31:0] rng_state;
    logic        stall_mode;            // Host ready held low
    int          held_slots;            // Committed slots not yet drained
    int          model_drops;
    frame_len_t  exp_len_q[$];
    logic [7:0]  exp_first_q[$];

    // Sink position inside the current output frame
    logic        in_frame;
    frame_len_t  cur_len;
    logic [7:0]  cur_first;
    int          cur_word;
    int          cur_words;
    int          frames_done;

    nic_rx_top u_nic_rx_top (
        .clk156_25        (clk156_25),
        .rst              (rst),
        .mac_rx_data      (mac_rx_data),
        .mac_rx_data_valid(mac_rx_data_valid),
        .mac_rx_good_frame(mac_rx_good_frame),
        .mac_rx_bad_frame (mac_rx_bad_frame),
        .pkt_data         (pkt_data),
        .pkt_keep         (pkt_keep),
        .pkt_sof          (pkt_sof),
        .pkt_eof          (pkt_eof),
        .pkt_len          (pkt_len),
        .pkt_src_rdy      (pkt_src_rdy),
        .pkt_dst_rdy      (pkt_dst_rdy),
        .dropped_pkts     (dropped_pkts)
    );

    initial begin
        clk156_25 = 1'b0;
        forever #10 clk156_25 = ~clk156_25;    // 50 MHz stand-in for 156.25
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Payload words without the header slot
    function automatic int word_count(input int len);
        return (len + LANES - 1) / LANES;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input mac_word_t exp_word,
                              input mac_valid_t exp_keep, input mac_word_t act_word,
                              input mac_valid_t act_keep);
        if (exp_word !== act_word || exp_keep !== act_keep) begin
            abort_run($sformatf("[ERROR] %s: expected %h keep %h, actual %h keep %h",
                                name, exp_word, exp_keep, act_word, act_keep));
        end
    endtask

    task automatic check_len(input string name, input frame_len_t exp_len,
                             input frame_len_t act_len);
        if (exp_len !== act_len) begin
            abort_run($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp_len, act_len));
        end
    endtask

    task automatic check_drops(input string name, input drop_cnt_t exp_cnt,
                               input drop_cnt_t act_cnt);
        if (exp_cnt !== act_cnt) begin
            abort_run($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp_cnt, act_cnt));
        end
    endtask

    task automatic check_flag(input string name, input logic exp_bit, input logic act_bit);
        if (exp_bit !== act_bit) begin
            abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp_bit, act_bit));
        end
    endtask

    // --------------------
    // Input timing
    // --------------------
    task automatic step_cycle();
        @(posedge clk156_25);
        #2;
        if (stall_mode) begin
            pkt_dst_rdy = 1'b0;
        end else begin
            rng_state   = xorshift32(rng_state);
            pkt_dst_rdy = rng_state[0];             // Random back-pressure
        end
    endtask

    task automatic wait_room(input int need);
        int n;
        n = 0;
        while (held_slots + need > DEPTH) begin
            if (n >= ROOM_TIMEOUT) begin
                abort_run("Timeout while waiting for the reader to free buffer space");
            end else begin
                step_cycle();
                n++;
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (held_slots != 0 || exp_len_q.size() != 0 || in_frame) begin
            if (n >= DRAIN_TIMEOUT) begin
                abort_run("Timeout while waiting for stored frames to drain");
            end else begin
                step_cycle();
                n++;
            end
        end
    endtask

    // One MAC frame and its end pulse on a cycle of its own
    task automatic drive_frame(input logic is_good, input int len, input int first);
        mac_word_t  w;
        mac_valid_t v;
        int         k;
        int         lane;
        int         idx;
        for (k = 0; k < word_count(len); k++) begin
            w = '0;
            v = '0;
            for (lane = 0; lane < LANES; lane++) begin
                idx = k * LANES + lane;
                if (idx < len) begin
                    w[8*lane +: 8] = 8'(first + idx);  // Incrementing bytes
                    v[lane]        = 1'b1;
                end
            end
            step_cycle();
            mac_rx_data       = w;
            mac_rx_data_valid = v;
        end
        step_cycle();
        mac_rx_data       = '0;
        mac_rx_data_valid = '0;
        mac_rx_good_frame = is_good;
        mac_rx_bad_frame  = !is_good;
        step_cycle();
        mac_rx_good_frame = 1'b0;                   // Drop count settled here
        mac_rx_bad_frame  = 1'b0;
    endtask

    // Predicts commit or drop and checks the drop count after the frame
    task automatic run_frame(input int line_no, input int kind, input int len,
                             input int first, input int stall, input int vec_drops);
        int   need;
        logic fits;
        need = word_count(len) + 1;
        if (stall != 0 && !stall_mode) begin
            wait_drain();                           // Stall phase starts empty
            stall_mode  = 1'b1;
            pkt_dst_rdy = 1'b0;
        end else if (stall == 0) begin
            stall_mode = 1'b0;
        end
        fits = 1'b0;
        if (kind != 0 && need <= DEPTH) begin
            if (!stall_mode) begin
                wait_room(need);
            end
            fits = (held_slots + need <= DEPTH);
        end
        if (fits) begin
            exp_len_q.push_back(frame_len_t'(len));
            exp_first_q.push_back(8'(first));
            held_slots += need;
        end else begin
            model_drops++;
        end
        drive_frame(kind != 0, len, first);
        check_drops($sformatf("drops after vector %0d", line_no), drop_cnt_t'(vec_drops),
                    dropped_pkts);
        if (model_drops != vec_drops) begin
            abort_run($sformatf("Vector %0d drop count disagrees with the buffer rules", line_no));
        end
    endtask

    // --------------------
    // Host sink
    // --------------------
    task automatic accept_word();
        mac_word_t  exp_word;
        mac_valid_t exp_keep;
        int         lane;
        int         idx;
        string      tag;
        if (!in_frame && exp_len_q.size() == 0) begin
            abort_run("Host port delivered a word while no committed frame was pending");
        end else begin
            if (!in_frame) begin
                cur_len   = exp_len_q.pop_front();
                cur_first = exp_first_q.pop_front();
                cur_words = word_count(int'(cur_len));
                cur_word  = 0;
                in_frame  = 1'b1;
            end
            tag      = $sformatf("frame %0d word %0d", frames_done, cur_word);
            exp_word = '0;
            exp_keep = '0;
            for (lane = 0; lane < LANES; lane++) begin
                idx = cur_word * LANES + lane;
                if (idx < int'(cur_len)) begin
                    exp_word[8*lane +: 8] = cur_first + 8'(idx);
                    exp_keep[lane]        = 1'b1;
                end
            end
            check_flag({tag, " sof"}, cur_word == 0, pkt_sof);
            if (cur_word == 0) begin
                check_len({tag, " len"}, cur_len, pkt_len);
            end
            check_word(tag, exp_word, exp_keep, pkt_data, pkt_keep);
            check_flag({tag, " eof"}, cur_word == cur_words - 1, pkt_eof);
            cur_word++;
            if (cur_word == cur_words) begin
                in_frame    = 1'b0;
                held_slots -= cur_words + 1;        // Reader frees header and words
                frames_done++;
            end
        end
    endtask

    // Mid-cycle sample before the transfer edge
    always @(negedge clk156_25) begin
        if (!rst && pkt_src_rdy && pkt_dst_rdy) begin
            accept_word();
        end
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int               fd;
        int               code;
        int               lines;
        int               kind;
        int               len;
        int               first;
        int               stall;
        int               vec_drops;
        logic [8*128-1:0] skip_line;
        rst               = 1'b1;
        mac_rx_data       = '0;
        mac_rx_data_valid = '0;
        mac_rx_good_frame = 1'b0;
        mac_rx_bad_frame  = 1'b0;
        pkt_dst_rdy       = 1'b0;
        rng_state         = 32'd34792;
        stall_mode        = 1'b0;
        held_slots        = 0;
        model_drops       = 0;
        in_frame          = 1'b0;
        cur_len           = '0;
        cur_first         = '0;
        cur_word          = 0;
        cur_words         = 0;
        frames_done       = 0;
        repeat (4) step_cycle();
        rst = 1'b0;
        step_cycle();
        check_flag("src_rdy after reset", 1'b0, pkt_src_rdy);
        check_drops("drops after reset", '0, dropped_pkts);

        fd = $fopen("testbench/nic_rx_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open testbench/nic_rx_vectors.txt");
        end else begin
            lines = 0;
            while (!$feof(fd) && lines < MAX_LINES) begin
                lines++;
                code = $fscanf(fd, " %d %d %h %d %d", kind, len, first, stall, vec_drops);
                if (code == 5) begin
                    run_frame(lines, kind, len, first, stall, vec_drops);
                end else if (!$feof(fd)) begin
                    code = $fgets(skip_line, fd);   // Column notes
                end
            end
            $fclose(fd);
        end

        stall_mode = 1'b0;                          // Release the host and drain the rest
        wait_drain();
        repeat (8) step_cycle();
        check_flag("src_rdy once drained", 1'b0, pkt_src_rdy);
        if (frames_done == 0) begin
            abort_run("No frame reached the host port");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

//--- testbench/nic_rx_vectors.txt
# kind (1 good, 0 bad), byte length, first byte in hex, stall (1 holds host ready low)
# last column is the expected dropped count after the frame
1 64 00 0 0
1 1 a0 0 0
1 13 10 0 0
0 40 55 0 1
1 8 20 0 1
1 71 33 0 1
0 9 77 0 2
1 600 01 0 3
1 255 c0 0 3
1 200 00 1 3
1 120 11 1 3
0 30 22 1 4
1 166 33 1 4
1 1 44 1 5
1 64 55 1 6
1 23 66 0 6
1 100 f0 0 6
0 16 08 0 7
1 57 e5 0 7
1 500 9c 0 7

//--- sources.f
+incdir+design
design/mac_rx_pkg.sv
design/rx_buf_pkg.sv
design/rx_frame_capture.sv
design/rx_packet_buffer.sv
design/rx_host_reader.sv
design/nic_rx_top.sv
testbench/nic_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the receive path testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module nic_rx_tb -o nic_rx_sim &&
./obj_dir/nic_rx_sim ||
{ echo "simulation did not complete cleanly"; exit 1; }
